/* Bender.yml */
package:
  name: riscmulti

sources:
  - files:
      - src/rvIsaPkg.sv
      - src/cpuUarchPkg.sv
      - src/alu.sv
      - src/immExtend.sv
      - src/regFile.sv
      - src/dataPath.sv
      - src/controller.sv
      - src/apbMaster.sv
      - src/riscMulti.sv
  - target: test
    files:
      - test/clkGen.sv
      - test/riscMultiTb.sv

/* riscMulti.f */
src/rvIsaPkg.sv
src/cpuUarchPkg.sv
src/alu.sv
src/immExtend.sv
src/regFile.sv
src/dataPath.sv
src/controller.sv
src/apbMaster.sv
src/riscMulti.sv
test/clkGen.sv
test/riscMultiTb.sv

/* src/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import rvIsaPkg::*; (
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  aluOp_t          op,
  output logic [XLEN-1:0] y,
  output logic            zero
);

  logic            subtract;
  logic [XLEN-1:0] bMod, sum;
  logic            lessThan;

  assign subtract = (op == ALU_SUB) || (op == ALU_SLT);
  assign bMod     = subtract ? ~b : b;
  assign sum      = a + bMod + XLEN'(subtract);  // one adder for add and sub

  // signed compare, signs differ means the negative one is smaller
  assign lessThan = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : sum[XLEN-1];

  always_comb begin
    case (op)
      ALU_AND: y = a & b;
      ALU_OR:  y = a | b;
      ALU_SLT: y = {{(XLEN-1){1'b0}}, lessThan};
      default: y = sum;  // add, sub
    endcase
  end

  assign zero = (y == '0);

endmodule

`default_nettype wire

/* src/apbMaster.sv */
`timescale 1ns/1ps
`default_nettype none

module apbMaster import rvIsaPkg::*, cpuUarchPkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  memCmd_t         memCmd,
  input  logic [XLEN-1:0] memAddr,
  input  logic [XLEN-1:0] memWdata,
  output logic            memDone,
  output logic [XLEN-1:0] memRdata,
  output apbReq_t         apbReq,
  input  apbRsp_t         apbRsp
);

  typedef enum logic [1:0] {APB_IDLE, APB_SETUP, APB_ACCESS} apbPhase_t;

  apbPhase_t       phase;
  logic            startXfer;
  logic            writeQ;
  logic [XLEN-1:0] addrQ, wdataQ;

  assign startXfer = (phase == APB_IDLE) && (memCmd != CMD_IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= APB_IDLE;
    end else begin
      case (phase)
        APB_IDLE:  if (startXfer) phase <= APB_SETUP;
        APB_SETUP: phase <= APB_ACCESS;
        default:   if (apbRsp.pready) phase <= APB_IDLE;  // wait states stretch access
      endcase
    end
  end

  // request captured once, held through access
  always_ff @(posedge clk) begin
    if (startXfer) begin
      addrQ  <= memAddr;
      wdataQ <= memWdata;
      writeQ <= (memCmd == CMD_WRITE);
    end
  end

  assign apbReq.psel    = (phase != APB_IDLE);
  assign apbReq.penable = (phase == APB_ACCESS);
  assign apbReq.pwrite  = writeQ;
  assign apbReq.paddr   = addrQ;
  assign apbReq.pwdata  = wdataQ;

  assign memDone  = (phase == APB_ACCESS) && apbRsp.pready;
  assign memRdata = apbRsp.prdata;  // only meaningful with memDone

  enableNeedsSel: assert property (@(posedge clk) disable iff (!rst_n)
    apbReq.penable |-> apbReq.psel);

  reqStable: assert property (@(posedge clk) disable iff (!rst_n)
    apbReq.penable |-> $stable({apbReq.paddr, apbReq.pwrite, apbReq.pwdata}));

  // controller has to hold its command until completion
  cmdHeld: assert property (@(posedge clk) disable iff (!rst_n)
    (phase != APB_IDLE) |-> $stable(memCmd));

endmodule

`default_nettype wire

/* src/controller.sv */
`timescale 1ns/1ps
`default_nettype none

module controller import rvIsaPkg::*, cpuUarchPkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [XLEN-1:0] instr,
  input  logic            zero,
  input  logic            memDone,
  output ctrl_t           ctrl,
  output memCmd_t         memCmd
);

  state_t     state, nextState;
  opcode_t    opcode;
  logic [2:0] funct3;
  logic       funct7b5;
  aluOp_t     funcOp;   // operation picked by funct3/funct7
  immType_t   immSel;

  assign opcode   = opcode_t'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign funct7b5 = instr[30];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state <= FETCH;
    else state <= nextState;
  end

  ////////////////////////////////////////////////////////////
  // alu and immediate decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (funct3)
      F3_ADD:  funcOp = (funct7b5 && opcode == OP_REG) ? ALU_SUB : ALU_ADD;
      F3_SLT:  funcOp = ALU_SLT;
      F3_OR:   funcOp = ALU_OR;
      F3_AND:  funcOp = ALU_AND;
      default: funcOp = ALU_ADD;
    endcase
  end

  always_comb begin
    case (opcode)
      OP_STORE:  immSel = IMM_S;
      OP_BRANCH: immSel = IMM_B;
      OP_JAL:    immSel = IMM_J;
      default:   immSel = IMM_I;  // loads and I-type ops
    endcase
  end

  ////////////////////////////////////////////////////////////
  // main FSM
  ////////////////////////////////////////////////////////////
  always_comb begin
    nextState   = state;
    memCmd      = CMD_IDLE;
    ctrl        = '0;
    ctrl.immSrc = immSel;
    ctrl.aluCtl = ALU_ADD;
    case (state)
      FETCH: begin
        memCmd         = CMD_READ;
        ctrl.srcB      = SRCB_STEP;  // pc + 4
        ctrl.resultSrc = RES_ALU;
        ctrl.irWrite   = memDone;
        ctrl.pcWrite   = memDone;
        if (memDone) nextState = DECODE;
      end
      DECODE: begin
        // branch/jump target lands in ALUOut
        ctrl.srcA = SRCA_OLDPC;
        ctrl.srcB = SRCB_IMM;
        case (opcode)
          OP_LOAD, OP_STORE: nextState = MEM_ADR;
          OP_REG:            nextState = EXEC_R;
          OP_IMM:            nextState = EXEC_I;
          OP_JAL:            nextState = JAL;
          OP_BRANCH:         nextState = BEQ;
          default:           nextState = FETCH;  // unknown op, no effect
        endcase
      end
      MEM_ADR: begin
        ctrl.srcA = SRCA_REG;
        ctrl.srcB = SRCB_IMM;
        if (opcode == OP_LOAD) nextState = MEM_READ;
        else nextState = MEM_WRITE;
      end
      MEM_READ: begin
        memCmd        = CMD_READ;
        ctrl.srcA     = SRCA_REG;  // keeps ALUOut on the address
        ctrl.srcB     = SRCB_IMM;
        ctrl.adrSrc   = 1'b1;
        ctrl.dataLoad = memDone;
        if (memDone) nextState = MEM_WB;
      end
      MEM_WRITE: begin
        memCmd      = CMD_WRITE;
        ctrl.srcA   = SRCA_REG;
        ctrl.srcB   = SRCB_IMM;
        ctrl.adrSrc = 1'b1;
        if (memDone) nextState = FETCH;
      end
      MEM_WB: begin
        ctrl.resultSrc = RES_DATA;
        ctrl.regWrite  = 1'b1;
        nextState      = FETCH;
      end
      EXEC_R: begin
        ctrl.srcA   = SRCA_REG;
        ctrl.aluCtl = funcOp;
        nextState   = ALU_WB;
      end
      EXEC_I: begin
        ctrl.srcA   = SRCA_REG;
        ctrl.srcB   = SRCB_IMM;
        ctrl.aluCtl = funcOp;
        nextState   = ALU_WB;
      end
      ALU_WB: begin
        ctrl.regWrite = 1'b1;
        nextState     = FETCH;
      end
      JAL: begin
        ctrl.srcA    = SRCA_OLDPC;  // link value for ALU_WB
        ctrl.srcB    = SRCB_STEP;
        ctrl.pcWrite = 1'b1;        // target from DECODE
        nextState    = ALU_WB;
      end
      BEQ: begin
        ctrl.srcA    = SRCA_REG;
        ctrl.aluCtl  = ALU_SUB;
        ctrl.pcWrite = zero;
        nextState    = FETCH;
      end
      default: nextState = FETCH;
    endcase
  end

  stateLegal: assert property (@(posedge clk) disable iff (!rst_n)
    state inside {FETCH, DECODE, MEM_ADR, MEM_READ, MEM_WB, MEM_WRITE,
                  EXEC_R, EXEC_I, ALU_WB, JAL, BEQ});

  // a completion only ever answers one of the memory states
  doneInMemState: assert property (@(posedge clk) disable iff (!rst_n)
    memDone |-> state inside {FETCH, MEM_READ, MEM_WRITE});

endmodule

`default_nettype wire

/* src/cpuUarchPkg.sv */
`default_nettype none

package cpuUarchPkg;

  import rvIsaPkg::*;

  ////////////////////////////////////////////////////////////
  // controller
  ////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    FETCH, DECODE, MEM_ADR, MEM_READ, MEM_WB, MEM_WRITE,
    EXEC_R, EXEC_I, ALU_WB, JAL, BEQ
  } state_t;

  typedef enum logic [1:0] {CMD_IDLE, CMD_READ, CMD_WRITE} memCmd_t;

  typedef enum logic [1:0] {SRCA_PC, SRCA_OLDPC, SRCA_REG} srcA_t;
  typedef enum logic [1:0] {SRCB_REG, SRCB_IMM, SRCB_STEP} srcB_t;
  typedef enum logic [1:0] {RES_ALUOUT, RES_DATA, RES_ALU} result_t;

  // control bundle from controller to datapath
  typedef struct packed {
    logic     pcWrite;
    logic     adrSrc;     // 0 = pc, 1 = result
    logic     irWrite;
    logic     dataLoad;
    logic     regWrite;
    result_t  resultSrc;
    srcA_t    srcA;
    srcB_t    srcB;
    immType_t immSrc;
    aluOp_t   aluCtl;
  } ctrl_t;

  ////////////////////////////////////////////////////////////
  // APB
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [XLEN-1:0] paddr;
    logic [XLEN-1:0] pwdata;
  } apbReq_t;

  typedef struct packed {
    logic [XLEN-1:0] prdata;
    logic            pready;
  } apbRsp_t;

endpackage

`default_nettype wire

/* src/dataPath.sv */
`timescale 1ns/1ps
`default_nettype none

module dataPath import rvIsaPkg::*, cpuUarchPkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  ctrl_t           ctrl,
  input  logic [XLEN-1:0] memRdata,
  output logic [XLEN-1:0] instr,
  output logic            zero,
  output logic [XLEN-1:0] memAddr,
  output logic [XLEN-1:0] memWdata
);

  logic [XLEN-1:0] pc, oldPc;
  logic [XLEN-1:0] data, regA, writeData, aluOut;  // non-architectural
  logic [XLEN-1:0] rd1, rd2, immExt;
  logic [XLEN-1:0] aluA, aluB, aluResult, result;

  ////////////////////////////////////////////////////////////
  // state registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc    <= '0;
      oldPc <= '0;
      instr <= '0;
    end else begin
      if (ctrl.pcWrite) pc <= result;
      if (ctrl.irWrite) begin
        oldPc <= pc;  // pc of the fetched instruction
        instr <= memRdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.dataLoad) data <= memRdata;
    regA      <= rd1;
    writeData <= rd2;
    aluOut    <= aluResult;
  end

  regFile regFile_i (
    .clk (clk),
    .we  (ctrl.regWrite),
    .ra1 (instr[19:15]),
    .ra2 (instr[24:20]),
    .wa  (instr[11:7]),
    .wd  (result),
    .rd1 (rd1),
    .rd2 (rd2)
  );

  immExtend immExtend_i (
    .instr  (instr),
    .immSrc (ctrl.immSrc),
    .imm    (immExt)
  );

  ////////////////////////////////////////////////////////////
  // alu sources and result select
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (ctrl.srcA)
      SRCA_OLDPC: aluA = oldPc;
      SRCA_REG:   aluA = regA;
      default:    aluA = pc;
    endcase
  end

  always_comb begin
    case (ctrl.srcB)
      SRCB_IMM:  aluB = immExt;
      SRCB_STEP: aluB = PC_STEP;
      default:   aluB = writeData;
    endcase
  end

  alu alu_i (
    .a    (aluA),
    .b    (aluB),
    .op   (ctrl.aluCtl),
    .y    (aluResult),
    .zero (zero)
  );

  always_comb begin
    case (ctrl.resultSrc)
      RES_DATA: result = data;
      RES_ALU:  result = aluResult;
      default:  result = aluOut;
    endcase
  end

  assign memAddr  = ctrl.adrSrc ? result : pc;
  assign memWdata = writeData;

endmodule

`default_nettype wire

/* src/immExtend.sv */
`timescale 1ns/1ps
`default_nettype none

module immExtend import rvIsaPkg::*; (
  input  logic [XLEN-1:0] instr,
  input  immType_t        immSrc,
  output logic [XLEN-1:0] imm
);

  always_comb begin
    case (immSrc)
      IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
      IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      // branch offset, halfword aligned
      IMM_B: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
      default: begin  // IMM_J
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
               instr[30:21], 1'b0};
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile import rvIsaPkg::*; (
  input  logic                  clk,
  input  logic                  we,
  input  logic [REG_ADDR_W-1:0] ra1,
  input  logic [REG_ADDR_W-1:0] ra2,
  input  logic [REG_ADDR_W-1:0] wa,
  input  logic [XLEN-1:0]       wd,
  output logic [XLEN-1:0]       rd1,
  output logic [XLEN-1:0]       rd2
);

  logic [XLEN-1:0] regs [2**REG_ADDR_W];

  always_ff @(posedge clk) begin
    if (we) regs[wa] <= wd;  // x0 may be written, never read back
  end

  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

/* src/riscMulti.sv */
`timescale 1ns/1ps
`default_nettype none

module riscMulti import rvIsaPkg::*, cpuUarchPkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  output apbReq_t apbReq,
  input  apbRsp_t apbRsp
);

  ctrl_t           ctrl;
  memCmd_t         memCmd;
  logic [XLEN-1:0] instr, memAddr, memWdata, memRdata;
  logic            zero, memDone;

  controller controller_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .instr   (instr),
    .zero    (zero),
    .memDone (memDone),
    .ctrl    (ctrl),
    .memCmd  (memCmd)
  );

  dataPath dataPath_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .memRdata (memRdata),
    .instr    (instr),
    .zero     (zero),
    .memAddr  (memAddr),
    .memWdata (memWdata)
  );

  apbMaster apbMaster_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .memCmd   (memCmd),
    .memAddr  (memAddr),
    .memWdata (memWdata),
    .memDone  (memDone),
    .memRdata (memRdata),
    .apbReq   (apbReq),
    .apbRsp   (apbRsp)
  );

endmodule

`default_nettype wire

/* src/rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  localparam logic [XLEN-1:0] PC_STEP = XLEN'(4);  // bytes per instruction

  ////////////////////////////////////////////////////////////
  // opcodes and funct3 fields of the supported subset
  ////////////////////////////////////////////////////////////
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,  // lw
    OP_STORE  = 7'b0100011,  // sw
    OP_REG    = 7'b0110011,  // add sub and or slt
    OP_IMM    = 7'b0010011,  // addi andi ori slti
    OP_BRANCH = 7'b1100011,  // beq
    OP_JAL    = 7'b1101111
  } opcode_t;

  localparam logic [2:0] F3_ADD = 3'b000;  // add, sub, addi
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // alu operations of the subset
  typedef enum logic [2:0] {
    ALU_ADD = 3'b000,
    ALU_SUB = 3'b001,
    ALU_AND = 3'b010,
    ALU_OR  = 3'b011,
    ALU_SLT = 3'b101
  } aluOp_t;

  typedef enum logic [1:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_J
  } immType_t;

endpackage

`default_nettype wire

/* test/clkGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clkGen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 20;  // 40 ns clock
  localparam int RESET_CYCLES = 4;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;  // released just after an edge
  end

endmodule

`default_nettype wire

/* test/riscMultiTb.sv */
`timescale 1ns/1ps
`default_nettype none

module riscMultiTb import rvIsaPkg::*, cpuUarchPkg::*; ();

  localparam int    MEM_WORDS     = 256;
  localparam int    IDX_W         = $clog2(MEM_WORDS);
  localparam int    MAX_WAIT      = 3;  // pready low cycles per access, at most
  localparam int    RESET_TIMEOUT = 20;
  localparam int    RUN_TIMEOUT   = 5000;
  localparam string TESTS_FILE    = "test/riscMultiTests.txt";

  logic    clk, rst_n;
  apbReq_t apbReq;
  apbRsp_t apbRsp;

  logic [XLEN-1:0] mem [MEM_WORDS];
  logic [XLEN-1:0] expAddr [$];  // expected stores, in order
  logic [XLEN-1:0] expData [$];

  // memory model state
  integer          seed;
  int              waitLeft;
  int              waitCycles;
  logic            prevRstN;
  logic            inAccess;  // last cycle was setup or a wait state
  logic            firstXfer;
  logic            heldWrite;
  logic [XLEN-1:0] heldAddr, heldWdata;

  clkGen clkGen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  riscMulti dut_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .apbReq (apbReq),
    .apbRsp (apbRsp)
  );

  ////////////////////////////////////////////////////////////
  // checking helpers
  ////////////////////////////////////////////////////////////
  task automatic failRun(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [XLEN-1:0] expected,
                            input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
      failRun("a checked value differs from its expected value");
    end
  endtask

  function automatic logic addrOk(input logic [XLEN-1:0] addr);
    return (addr[1:0] == 2'b00) && (addr < XLEN'(MEM_WORDS * 4));
  endfunction

  task automatic checkStore(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
    logic [XLEN-1:0] wantAddr;
    logic [XLEN-1:0] wantData;
    if (expAddr.size() == 0) failRun("the core stored a word after the last expected store");
    wantAddr = expAddr.pop_front();
    wantData = expData.pop_front();
    checkValue("store paddr", wantAddr, addr);
    checkValue("store pwdata", wantData, data);
  endtask

  ////////////////////////////////////////////////////////////
  // tests file
  ////////////////////////////////////////////////////////////
  task automatic loadTests();
    int              fd;
    int              c;
    int              count;
    int              i;
    logic [XLEN-1:0] addr, value;
    for (i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'hDEAD0000 ^ XLEN'(i * 4);  // byte address in the fill
    end
    fd = $fopen(TESTS_FILE, "r");
    if (fd == 0) failRun("could not open the tests file");
    c = 0;
    while (c != -1) begin
      c = $fgetc(fd);
      if (c == "#") begin
        // comment runs to end of line
        while (c != "\n" && c != -1) c = $fgetc(fd);
      end else if (c == "P" || c == "S") begin
        count = $fscanf(fd, "%h %h", addr, value);
        if (count != 2) failRun("a line of the tests file is malformed");
        if (c == "P") begin
          if (!addrOk(addr)) failRun("a program word lies outside the memory model");
          mem[addr[IDX_W+1:2]] = value;
        end else begin
          expAddr.push_back(addr);
          expData.push_back(value);
        end
      end
    end
    $fclose(fd);
    if (expAddr.size() == 0) failRun("the tests file holds no expected stores");
  endtask

  ////////////////////////////////////////////////////////////
  // bounded waits
  ////////////////////////////////////////////////////////////
  task automatic waitForReset();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > RESET_TIMEOUT) failRun("reset was never released");
    end
  endtask

  task automatic waitForStores();
    int cycles;
    cycles = 0;
    while (expAddr.size() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > RUN_TIMEOUT) failRun("timed out waiting for the expected stores");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // APB memory model with random wait states
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    prevRstN <= rst_n;
    if ((!rst_n || !prevRstN) && (apbReq.psel || apbReq.penable)) begin
      failRun("psel or penable was high during or right after reset");
    end
    if (!rst_n) begin
      apbRsp.pready <= 1'b0;
      inAccess      <= 1'b0;
    end else if (apbReq.psel && !apbReq.penable) begin
      // setup cycle just ended
      if (firstXfer) begin
        checkValue("first pwrite", '0, XLEN'(apbReq.pwrite));
        checkValue("first paddr", '0, apbReq.paddr);
        firstXfer <= 1'b0;
      end
      if (!addrOk(apbReq.paddr)) failRun("a transfer address lies outside the memory model");
      heldAddr   <= apbReq.paddr;
      heldWrite  <= apbReq.pwrite;
      heldWdata  <= apbReq.pwdata;
      inAccess   <= 1'b1;
      waitCycles = {$random(seed)} % (MAX_WAIT + 1);
      waitLeft   <= waitCycles;
      if (waitCycles == 0) begin
        apbRsp.pready <= 1'b1;
        apbRsp.prdata <= mem[apbReq.paddr[IDX_W+1:2]];
      end
    end else if (apbReq.penable) begin
      if (!apbReq.psel || !inAccess) failRun("an access cycle came without a setup cycle");
      checkValue("paddr", heldAddr, apbReq.paddr);  // held since setup
      checkValue("pwrite", XLEN'(heldWrite), XLEN'(apbReq.pwrite));
      checkValue("pwdata", heldWdata, apbReq.pwdata);
      if (apbRsp.pready) begin
        apbRsp.pready <= 1'b0;
        inAccess      <= 1'b0;
        if (apbReq.pwrite) begin
          mem[apbReq.paddr[IDX_W+1:2]] = apbReq.pwdata;
          checkStore(apbReq.paddr, apbReq.pwdata);
        end
      end else begin
        if (waitLeft == 1) begin
          apbRsp.pready <= 1'b1;
          apbRsp.prdata <= mem[apbReq.paddr[IDX_W+1:2]];
        end
        waitLeft <= waitLeft - 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    seed      = 32'h4882;
    apbRsp    = '0;
    prevRstN  = 1'b0;
    inAccess  = 1'b0;
    firstXfer = 1'b1;
    waitLeft  = 0;
    loadTests();  // before reset goes away
    waitForReset();
    waitForStores();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* test/riscMultiTests.txt */
# P <byte address> <instruction word>  program image, loaded before reset
# S <byte address> <store data>  expected stores on the APB bus, in order
P 00000000 00C00093  # addi x1, x0, 12
P 00000004 FFA00113  # addi x2, x0, -6
P 00000008 002081B3  # add  x3, x1, x2
P 0000000C 20302023  # sw   x3, 0x200(x0)
P 00000010 40208233  # sub  x4, x1, x2
P 00000014 20402223  # sw   x4, 0x204(x0)
P 00000018 0020F2B3  # and  x5, x1, x2
P 0000001C 20502423  # sw   x5, 0x208(x0)
P 00000020 0020E333  # or   x6, x1, x2
P 00000024 20602623  # sw   x6, 0x20c(x0)
P 00000028 001123B3  # slt  x7, x2, x1
P 0000002C 20702823  # sw   x7, 0x210(x0)
P 00000030 0020A433  # slt  x8, x1, x2
P 00000034 20802A23  # sw   x8, 0x214(x0)
P 00000038 FEC08513  # addi x10, x1, -20
P 0000003C 00F17593  # andi x11, x2, 0xf
P 00000040 7010E613  # ori  x12, x1, 0x701
P 00000044 FFB12693  # slti x13, x2, -5
P 00000048 FFF0A713  # slti x14, x1, -1
P 0000004C 20A02C23  # sw   x10, 0x218(x0)
P 00000050 20B02E23  # sw   x11, 0x21c(x0)
P 00000054 22C02023  # sw   x12, 0x220(x0)
P 00000058 22D02223  # sw   x13, 0x224(x0)
P 0000005C 22E02423  # sw   x14, 0x228(x0)
P 00000060 20402783  # lw   x15, 0x204(x0)
P 00000064 20C02803  # lw   x16, 0x20c(x0)
P 00000068 010788B3  # add  x17, x15, x16
P 0000006C 23102623  # sw   x17, 0x22c(x0)
P 00000070 04D00013  # addi x0, x0, 77
P 00000074 22002823  # sw   x0, 0x230(x0)
P 00000078 00108463  # beq  x1, x1, +8   taken
P 0000007C 22102A23  # sw   x1, 0x234(x0)   must be skipped
P 00000080 00208463  # beq  x1, x2, +8   not taken
P 00000084 22202A23  # sw   x2, 0x234(x0)
P 00000088 00C009EF  # jal  x19, +12
P 0000008C 22102C23  # sw   x1, 0x238(x0)   must be skipped
P 00000090 22102C23  # sw   x1, 0x238(x0)   must be skipped
P 00000094 23302C23  # sw   x19, 0x238(x0)
P 00000098 0000006F  # jal  x0, 0   self loop
# expected stores
S 00000200 00000006  # 12 + -6
S 00000204 00000012  # 12 - -6
S 00000208 00000008  # 12 & -6
S 0000020C FFFFFFFE  # 12 | -6
S 00000210 00000001  # -6 < 12 signed
S 00000214 00000000  # 12 < -6 signed
S 00000218 FFFFFFF8  # 12 + -20
S 0000021C 0000000A  # -6 & 0xf
S 00000220 0000070D  # 12 | 0x701
S 00000224 00000001  # -6 < -5
S 00000228 00000000  # 12 < -1
S 0000022C 00000010  # 0x12 + 0xfffffffe from loads
S 00000230 00000000  # x0 stays zero
S 00000234 FFFFFFFA  # store after the not-taken beq
S 00000238 0000008C  # jal link, pc + 4
